//--- xt_bus_chipset.f
+incdir+include
rtl/xt_bus_pkg.sv
rtl/bus_cycle_control.sv
rtl/address_latch_decode.sv
rtl/data_bus_steering.sv
rtl/refresh_request.sv
rtl/xt_bus_chipset.sv
testbench/xt_bus_chipset_checker.sv
testbench/xt_bus_chipset_tb.sv

//--- Bender.yml
package:
  name: xt_bus_chipset

sources:
  - include_dirs:
      - include
    files:
      - rtl/xt_bus_pkg.sv
      - rtl/bus_cycle_control.sv
      - rtl/address_latch_decode.sv
      - rtl/data_bus_steering.sv
      - rtl/refresh_request.sv
      - rtl/xt_bus_chipset.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/xt_bus_chipset_checker.sv
      - testbench/xt_bus_chipset_tb.sv

//--- testbench/xt_bus_chipset_tb.sv
// ********************
// Testbench for the XT bus chipset core. Runs a table of bus
// cycles the way an 8088 would, then the halt and refresh cases.
// ********************
`timescale 1ns/1ns
`include "xt_bus_chipset_settings.svh"

module xt_bus_chipset_tb
    import xt_bus_pkg::*;
();

    localparam int CLOCK_PERIOD = 10;
    localparam int ENTRY_COUNT  = 8;

    localparam bus_command_t strobe_idle      = 5'b11111;
    localparam bus_command_t strobe_io_read   = 5'b01111;
    localparam bus_command_t strobe_io_write  = 5'b10111;
    localparam bus_command_t strobe_mem_read  = 5'b11011;
    localparam bus_command_t strobe_mem_write = 5'b11101;
    localparam bus_command_t strobe_inta      = 5'b11110;

    localparam region_select_t no_region  = 2'b00;
    localparam region_select_t ram_region = 2'b10;
    localparam region_select_t io_region  = 2'b01;

    // Where the read byte should come from
    typedef enum logic [1:0] {from_none, from_chipset, from_ram, from_external} source_e;

    typedef struct packed
    {
        bus_status_e                       status;
        logic [`CHIPSET_ADDRESS_WIDTH-1:0] address;
        logic [3:0]                        holdoff;
        bus_command_t                      command;
        cycle_kind_e                       kind;
        region_select_t                    region;
        source_e                           source;
        data_byte_t                        write_byte;
        data_byte_t                        chipset_byte;
        data_byte_t                        ram_byte;
        data_byte_t                        external_byte;
    } stimulus_t;

    logic                              clock;
    logic                              reset;
    bus_status_e                       processor_status;
    logic [`CHIPSET_ADDRESS_WIDTH-1:0] cpu_address;
    data_byte_t                        cpu_data_bus;
    logic                              io_channel_ready;
    logic                              memory_access_ready;
    data_byte_t                        chipset_data;
    data_byte_t                        ram_data;
    data_byte_t                        data_bus_ext;
    logic                              timer_1_out;
    logic                              dma_acknowledge_0_n;
    logic                              processor_ready;
    logic                              address_latch_enable;
    latched_bus_t                      address;
    bus_command_t                      command;
    data_byte_t                        cpu_read_data;
    data_byte_t                        data_bus;
    logic                              data_bus_direction;
    logic                              dma_request_0;

    stimulus_t table_entries [ENTRY_COUNT];
    integer    seed;

    xt_bus_chipset DUT (.*);

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic report_mismatch(input string what, input string detail);
        $display("mismatch at %0t ns: %s, %s", $time, what, detail);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_command(input bus_command_t actual, input bus_command_t expected,
                                 input string what);
        if (actual !== expected)
            report_mismatch(what, $sformatf("expected %b got %b", expected, actual));
    endtask

    task automatic check_byte(input data_byte_t actual, input data_byte_t expected,
                              input string what);
        if (actual !== expected)
            report_mismatch(what, $sformatf("expected %h got %h", expected, actual));
    endtask

    task automatic check_address(input latched_bus_t actual, input latched_bus_t expected,
                                 input string what);
        if (actual !== expected)
            report_mismatch(what, $sformatf("expected %h got %h", expected, actual));
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            report_mismatch(what, $sformatf("expected %b got %b", expected, actual));
    endtask

    function automatic data_byte_t random_byte();
        return data_byte_t'($random(seed));
    endfunction

    function automatic stimulus_t entry_for(input bus_status_e status,
                                            input logic [`CHIPSET_ADDRESS_WIDTH-1:0] address,
                                            input logic [3:0] holdoff,
                                            input bus_command_t strobes,
                                            input cycle_kind_e kind,
                                            input region_select_t region,
                                            input source_e source);
        stimulus_t entry;
        entry = '{status, address, holdoff, strobes, kind, region, source,
                  random_byte(), random_byte(), random_byte(), random_byte()};
        return entry;
    endfunction

    function automatic data_byte_t expected_read(input stimulus_t entry);
        case (entry.source)
            from_chipset:  return entry.chipset_byte;
            from_ram:      return entry.ram_byte;
            from_external: return entry.external_byte;
            default:       return '0;
        endcase
    endfunction

    task automatic run_bus_cycle(input stimulus_t entry, input logic hold_memory);
        int           edges;
        int           ready_edge;
        latched_bus_t expected_bus;
        // Strobe falls at edge 2, ready needs the wait state and both ready inputs
        ready_edge   = (int'(entry.holdoff) + 1 > 4) ? int'(entry.holdoff) + 1 : 4;
        expected_bus = '{entry.address, entry.kind};
        @(posedge clock);
        processor_status    <= entry.status;
        cpu_address         <= entry.address;
        cpu_data_bus        <= entry.write_byte;
        chipset_data        <= entry.chipset_byte;
        ram_data            <= entry.ram_byte;
        data_bus_ext        <= entry.external_byte;
        io_channel_ready    <= (entry.holdoff == 0) || hold_memory;
        memory_access_ready <= (entry.holdoff == 0) || !hold_memory;
        edges = 0;
        while (!processor_ready)
        begin
            @(posedge clock);
            edges++;
            if (edges == entry.holdoff)
            begin
                io_channel_ready    <= 1'b1;
                memory_access_ready <= 1'b1;
            end
            @(negedge clock);
            check_flag(address_latch_enable, edges == 1, "ALE pulse");
            check_flag(processor_ready, edges >= ready_edge, "ready timing");
            if (edges >= 2)
                check_command(command, entry.command, "strobe during cycle");
        end
        check_address(address, expected_bus, "latched address");
        check_byte(cpu_read_data, expected_read(entry), "read byte");
        check_flag(data_bus_direction, entry.source == from_external, "data bus direction");
        check_flag(DUT.region.ram_select, entry.region.ram_select, "RAM select");
        check_flag(DUT.region.chipset_select, entry.region.chipset_select, "chipset select");
        if (entry.source == from_none)
            check_byte(data_bus, entry.write_byte, "write byte");
        @(posedge clock);
        processor_status <= status_passive;
        @(negedge clock);
        check_command(command, entry.command, "strobe held until passive");
        check_flag(processor_ready, 1'b1, "ready held until passive");
        @(posedge clock);
        @(negedge clock);
        check_command(command, strobe_idle, "strobes after cycle");
        check_flag(processor_ready, 1'b0, "ready after cycle");
        check_byte(cpu_read_data, '0, "read byte when idle");
        check_byte(data_bus, '0, "data bus when idle");
        check_flag(data_bus_direction, 1'b0, "direction when idle");
    endtask

    task automatic try_halt();
        @(posedge clock);
        processor_status <= status_halt;
        repeat (5)
        begin
            @(negedge clock);
            check_flag(address_latch_enable, 1'b0, "ALE on halt");
            check_command(command, strobe_idle, "strobes on halt");
        end
        @(posedge clock);
        processor_status <= status_passive;
    endtask

    task automatic exercise_refresh();
        @(posedge clock);
        timer_1_out <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        check_flag(dma_request_0, 1'b1, "request after timer edge");
        @(posedge clock);
        timer_1_out <= 1'b0;
        @(posedge clock);
        @(negedge clock);
        check_flag(dma_request_0, 1'b1, "request held");
        // New timer edge and acknowledge on the same clock
        @(posedge clock);
        timer_1_out         <= 1'b1;
        dma_acknowledge_0_n <= 1'b0;
        @(posedge clock);
        @(negedge clock);
        check_flag(dma_request_0, 1'b0, "acknowledge against new edge");
        @(posedge clock);
        dma_acknowledge_0_n <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        check_flag(dma_request_0, 1'b0, "request stays clear");
    endtask

    initial
    begin
        #((ENTRY_COUNT * 40 + 200) * CLOCK_PERIOD);
        $display("Timeout: the bus cycles did not finish in time");
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        wait (DUT.u_bus_cycle_control.cycle_assertions.failure_count != 0 ||
              DUT.u_refresh_request.refresh_assertions.failure_count != 0);
        $display("A bound assertion on the strobes or the refresh request failed");
        $display("Something failed");
        $fatal(1, "assertion failure");
    end

    initial
    begin
        seed                = 32'h9889_5b15;
        clock               = 1'b0;
        reset               = 1'b1;
        processor_status    = status_passive;
        cpu_address         = '0;
        cpu_data_bus        = '0;
        io_channel_ready    = 1'b1;
        memory_access_ready = 1'b1;
        chipset_data        = '0;
        ram_data            = '0;
        data_bus_ext        = '0;
        timer_1_out         = 1'b0;
        dma_acknowledge_0_n = 1'b1;
        table_entries[0] = entry_for(status_io_read, 20'h00060, 4'd0, strobe_io_read,
                                     cycle_io, io_region, from_chipset);
        table_entries[1] = entry_for(status_io_read, 20'h00100, 4'd2, strobe_io_read,
                                     cycle_io, no_region, from_external);
        table_entries[2] = entry_for(status_io_write, 20'h00061, 4'd0, strobe_io_write,
                                     cycle_io, io_region, from_none);
        table_entries[3] = entry_for(status_code_fetch, 20'h00400, 4'd0, strobe_mem_read,
                                     cycle_memory, ram_region, from_ram);
        table_entries[4] = entry_for(status_memory_read, 20'h9FFFF, 4'd1, strobe_mem_read,
                                     cycle_memory, ram_region, from_ram);
        table_entries[5] = entry_for(status_memory_read, 20'hA0000, 4'd5, strobe_mem_read,
                                     cycle_memory, no_region, from_external);
        table_entries[6] = entry_for(status_memory_write, 20'hB8000, 4'd3, strobe_mem_write,
                                     cycle_memory, no_region, from_none);
        table_entries[7] = entry_for(status_interrupt_acknowledge, 20'h00000, 4'd0,
                                     strobe_inta, cycle_interrupt, no_region, from_external);
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_flag(address_latch_enable, 1'b0, "ALE after reset");
        check_command(command, strobe_idle, "strobes after reset");
        check_flag(processor_ready, 1'b0, "ready after reset");
        check_flag(dma_request_0, 1'b0, "refresh request after reset");
        check_address(address, '0, "address after reset");
        for (int i = 0; i < ENTRY_COUNT; i++)
            run_bus_cycle(table_entries[i], (i % 2) == 1);
        try_halt();
        exercise_refresh();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- testbench/xt_bus_chipset_checker.sv
// ********************
// Concurrent assertions on the command strobes, ALE and the
// refresh request, bound into the chipset blocks.
// ********************
`timescale 1ns/1ns

module xt_bus_chipset_checker
    import xt_bus_pkg::*;
(
    input logic         clock,
    input logic         reset,
    input logic         address_latch_enable,
    input bus_command_t command,
    input logic         dma_request_0,
    input logic         dma_acknowledge_0_n
);

    // Number of failed assertions
    int failure_count = 0;

    // ALE lasts a single clock
    ale_single_cycle: assert property (@(posedge clock) disable iff (reset)
        address_latch_enable |=> !address_latch_enable)
        else
        begin
            $error("address latch enable high for two cycles");
            failure_count++;
        end

    one_strobe_low: assert property (@(posedge clock) disable iff (reset)
        $countones(~command) <= 1)
        else
        begin
            $error("more than one command strobe low");
            failure_count++;
        end

    acknowledge_clears: assert property (@(posedge clock) disable iff (reset)
        !dma_acknowledge_0_n |=> !dma_request_0)
        else
        begin
            $error("refresh request not cleared after acknowledge");
            failure_count++;
        end

endmodule

// Inputs a block does not have are tied to their idle levels
bind bus_cycle_control xt_bus_chipset_checker cycle_assertions
(
    .clock                (clock),
    .reset                (reset),
    .address_latch_enable (address_latch_enable),
    .command              (command),
    .dma_request_0        (1'b0),
    .dma_acknowledge_0_n  (1'b1)
);

bind refresh_request xt_bus_chipset_checker refresh_assertions
(
    .clock                (clock),
    .reset                (reset),
    .address_latch_enable (1'b0),
    .command              (5'b11111),
    .dma_request_0        (dma_request_0),
    .dma_acknowledge_0_n  (dma_acknowledge_0_n)
);

//--- rtl/xt_bus_chipset.sv
// ********************
// Top of the XT bus chipset core. Connects cycle control,
// address decode, data steering and the refresh request.
// ********************
`timescale 1ns/1ns
`include "xt_bus_chipset_settings.svh"

module xt_bus_chipset
    import xt_bus_pkg::*;
(
    input  logic                              clock,
    input  logic                              reset,
    input  bus_status_e                       processor_status,
    input  logic [`CHIPSET_ADDRESS_WIDTH-1:0] cpu_address,
    input  data_byte_t                        cpu_data_bus,
    input  logic                              io_channel_ready,
    input  logic                              memory_access_ready,
    input  data_byte_t                        chipset_data,
    input  data_byte_t                        ram_data,
    input  data_byte_t                        data_bus_ext,
    input  logic                              timer_1_out,
    input  logic                              dma_acknowledge_0_n,
    output logic                              processor_ready,
    output logic                              address_latch_enable,
    output latched_bus_t                      address,
    output bus_command_t                      command,
    output data_byte_t                        cpu_read_data,
    output data_byte_t                        data_bus,
    output logic                              data_bus_direction,
    output logic                              dma_request_0
);

    cycle_kind_e    cycle_kind;
    region_select_t region;

    bus_cycle_control u_bus_cycle_control
    (
        .clock                (clock),
        .reset                (reset),
        .processor_status     (processor_status),
        .io_channel_ready     (io_channel_ready),
        .memory_access_ready  (memory_access_ready),
        .address_latch_enable (address_latch_enable),
        .cycle_kind           (cycle_kind),
        .command              (command),
        .processor_ready      (processor_ready)
    );

    address_latch_decode u_address_latch_decode
    (
        .clock                (clock),
        .reset                (reset),
        .address_latch_enable (address_latch_enable),
        .cpu_address          (cpu_address),
        .cycle_kind           (cycle_kind),
        .latched              (address),
        .region               (region)
    );

    data_bus_steering u_data_bus_steering
    (
        .command              (command),
        .region               (region),
        .chipset_data         (chipset_data),
        .ram_data             (ram_data),
        .data_bus_ext         (data_bus_ext),
        .cpu_data_bus         (cpu_data_bus),
        .cpu_read_data        (cpu_read_data),
        .data_bus             (data_bus),
        .data_bus_direction   (data_bus_direction)
    );

    refresh_request u_refresh_request
    (
        .clock                (clock),
        .reset                (reset),
        .timer_1_out          (timer_1_out),
        .dma_acknowledge_0_n  (dma_acknowledge_0_n),
        .dma_request_0        (dma_request_0)
    );

endmodule

//--- rtl/refresh_request.sv
// ********************
// DRAM refresh request for DMA channel 0, raised by timer 1
// and held until the channel acknowledges.
// ********************
`timescale 1ns/1ns

module refresh_request
(
    input  logic clock,
    input  logic reset,
    input  logic timer_1_out,
    input  logic dma_acknowledge_0_n,
    output logic dma_request_0
);

    logic previous_timer;
    logic timer_rise;

    // Starts high so a level out of reset is no edge
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            previous_timer <= 1'b1;
        else
            previous_timer <= timer_1_out;
    end

    assign timer_rise = ~previous_timer & timer_1_out;

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            dma_request_0 <= 1'b0;
        else if (!dma_acknowledge_0_n)
            dma_request_0 <= 1'b0;
        else if (timer_rise)
            dma_request_0 <= 1'b1;
    end

endmodule

//--- rtl/data_bus_steering.sv
// ********************
// Picks the byte returned to the CPU and drives the outbound
// data bus and its direction from the active strobe.
// ********************
`timescale 1ns/1ns

module data_bus_steering
    import xt_bus_pkg::*;
(
    input  bus_command_t   command,
    input  region_select_t region,
    input  data_byte_t     chipset_data,
    input  data_byte_t     ram_data,
    input  data_byte_t     data_bus_ext,
    input  data_byte_t     cpu_data_bus,
    output data_byte_t     cpu_read_data,
    output data_byte_t     data_bus,
    output logic           data_bus_direction
);

    logic read_strobe;
    logic write_strobe;

    assign read_strobe  = ~command.io_read_n | ~command.memory_read_n |
                          ~command.interrupt_acknowledge_n;
    assign write_strobe = ~command.io_write_n | ~command.memory_write_n;

    always_comb
    begin
        cpu_read_data      = '0;
        data_bus           = '0;
        data_bus_direction = 1'b0;
        if (!command.io_read_n && region.chipset_select)
        begin
            cpu_read_data = chipset_data;
            data_bus      = chipset_data;
        end
        else if (!command.memory_read_n && region.ram_select)
        begin
            cpu_read_data = ram_data;
            data_bus      = ram_data;
        end
        else if (read_strobe)
        begin
            // Nothing local answers, take it from the slot bus
            cpu_read_data      = data_bus_ext;
            data_bus_direction = 1'b1;
        end
        else if (write_strobe)
            data_bus = cpu_data_bus;
    end

endmodule

//--- rtl/address_latch_decode.sv
// ********************
// Latches the CPU address on ALE and decodes the RAM and
// local chipset I/O regions for the running cycle.
// ********************
`timescale 1ns/1ns
`include "xt_bus_chipset_settings.svh"

module address_latch_decode
    import xt_bus_pkg::*;
(
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              address_latch_enable,
    input  logic [`CHIPSET_ADDRESS_WIDTH-1:0] cpu_address,
    input  cycle_kind_e                       cycle_kind,
    output latched_bus_t                      latched,
    output region_select_t                    region
);

    logic below_ram_top;
    logic below_io_local_top;

    // Held from ALE until the next cycle starts
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            latched <= '0;
        else if (address_latch_enable)
        begin
            latched.address <= cpu_address;
            latched.kind    <= cycle_kind;
        end
    end

    assign below_ram_top      = latched.address < `CHIPSET_RAM_TOP;
    assign below_io_local_top = latched.address < `CHIPSET_IO_LOCAL_TOP;

    always_comb
    begin
        region.ram_select     = (latched.kind == cycle_memory) && below_ram_top;
        // Only the low ports belong to the chipset
        region.chipset_select = (latched.kind == cycle_io) && below_io_local_top;
    end

endmodule

//--- rtl/bus_cycle_control.sv
// ********************
// Bus cycle FSM. Turns the CPU status into ALE, one command
// strobe and the processor ready level, with fixed wait states.
// ********************
`timescale 1ns/1ns
`include "xt_bus_chipset_settings.svh"

module bus_cycle_control
    import xt_bus_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  bus_status_e  processor_status,
    input  logic         io_channel_ready,
    input  logic         memory_access_ready,
    output logic         address_latch_enable,
    output cycle_kind_e  cycle_kind,
    output bus_command_t command,
    output logic         processor_ready
);

    typedef enum logic [1:0]
    {
        state_idle,
        state_address,
        state_command,
        state_done
    } state_e;

    state_e                               state;
    bus_status_e                          cycle_status;
    logic [`CHIPSET_WAIT_COUNT_WIDTH-1:0] wait_count;
    logic                                 starts_cycle;
    logic                                 channel_ready;

    // Halt and passive never open a cycle
    assign starts_cycle  = (processor_status != status_passive) &&
                           (processor_status != status_halt);
    assign channel_ready = io_channel_ready & memory_access_ready;

    function automatic bus_command_t command_for(input bus_status_e status);
        bus_command_t strobes;
        strobes = '1;
        case (status)
            status_interrupt_acknowledge: strobes.interrupt_acknowledge_n = 1'b0;
            status_io_read:               strobes.io_read_n = 1'b0;
            status_io_write:              strobes.io_write_n = 1'b0;
            status_code_fetch:            strobes.memory_read_n = 1'b0;
            status_memory_read:           strobes.memory_read_n = 1'b0;
            status_memory_write:          strobes.memory_write_n = 1'b0;
            default:                      strobes = '1;
        endcase
        return strobes;
    endfunction

    function automatic cycle_kind_e kind_for(input bus_status_e status);
        case (status)
            status_interrupt_acknowledge:            return cycle_interrupt;
            status_io_read, status_io_write:         return cycle_io;
            status_code_fetch, status_memory_read,
            status_memory_write:                     return cycle_memory;
            default:                                 return cycle_none;
        endcase
    endfunction

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            state                <= state_idle;
            cycle_status         <= status_passive;
            cycle_kind           <= cycle_none;
            address_latch_enable <= 1'b0;
            command              <= '1;
            processor_ready      <= 1'b0;
            wait_count           <= '0;
        end
        else
        begin
            // ALE is a single-cycle pulse
            address_latch_enable <= 1'b0;
            case (state)
                state_idle:
                    if (starts_cycle)
                    begin
                        state                <= state_address;
                        address_latch_enable <= 1'b1;
                        cycle_status         <= processor_status;
                        cycle_kind           <= kind_for(processor_status);
                    end
                state_address:
                begin
                    command    <= command_for(cycle_status);
                    wait_count <= `CHIPSET_WAIT_STATES;
                    state      <= state_command;
                end
                state_command:
                    if (wait_count != '0)
                        wait_count <= wait_count - 1'b1;
                    else if (channel_ready)
                    begin
                        processor_ready <= 1'b1;
                        state           <= state_done;
                    end
                state_done:
                    // CPU ends the cycle by going passive
                    if (processor_status == status_passive)
                    begin
                        processor_ready <= 1'b0;
                        command         <= '1;
                        cycle_kind      <= cycle_none;
                        state           <= state_idle;
                    end
                default:
                    state <= state_idle;
            endcase
        end
    end

endmodule

//--- rtl/xt_bus_pkg.sv
// ********************
// Types shared by the XT bus chipset blocks.
// Import by wildcard in the module header.
// ********************
`include "xt_bus_chipset_settings.svh"

package xt_bus_pkg;

    // 8088 S2..S0 status codes
    typedef enum logic [2:0]
    {
        status_interrupt_acknowledge = 3'b000,
        status_io_read               = 3'b001,
        status_io_write              = 3'b010,
        status_halt                  = 3'b011,
        status_code_fetch            = 3'b100,
        status_memory_read           = 3'b101,
        status_memory_write          = 3'b110,
        status_passive               = 3'b111
    } bus_status_e;

    // Command strobes, all active low
    typedef struct packed
    {
        logic io_read_n;
        logic io_write_n;
        logic memory_read_n;
        logic memory_write_n;
        logic interrupt_acknowledge_n;
    } bus_command_t;

    typedef enum logic [1:0]
    {
        cycle_none,
        cycle_memory,
        cycle_io,
        cycle_interrupt
    } cycle_kind_e;

    typedef struct packed
    {
        logic [`CHIPSET_ADDRESS_WIDTH-1:0] address;
        cycle_kind_e                       kind;
    } latched_bus_t;

    typedef struct packed
    {
        logic ram_select;
        logic chipset_select;
    } region_select_t;

    typedef logic [`CHIPSET_DATA_WIDTH-1:0] data_byte_t;

endpackage

//--- include/xt_bus_chipset_settings.svh
// ********************
// Bus widths, decode limits and wait states for the XT chipset core.
// Included by the package and by RTL that uses these values.
// ********************
`ifndef XT_BUS_CHIPSET_SETTINGS_SVH
`define XT_BUS_CHIPSET_SETTINGS_SVH

// CPU address and data bus
`define CHIPSET_ADDRESS_WIDTH 20
`define CHIPSET_DATA_WIDTH 8

// First memory address above on-board RAM
`define CHIPSET_RAM_TOP 20'hA0000

// First I/O port outside the chipset
`define CHIPSET_IO_LOCAL_TOP 20'h00100

// Wait states added to every bus cycle
`define CHIPSET_WAIT_COUNT_WIDTH 2
`define CHIPSET_WAIT_STATES 2'd1

`endif
